/* src/fb_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// geometry, widths, types and structs shared by the scaled framebuffer
// display blocks, referenced everywhere as fb_pkg::name
////////////////////////////////////////////////////////////////////////////

package fb_pkg;

    // display geometry, 640x480 active area
    localparam int H_RES   = 640;
    localparam int V_RES   = 480;
    localparam int H_BLANK = 160;  // sx runs -160..639
    localparam int V_BLANK = 45;   // sy runs -45..479

    // framebuffer and palette
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_SCALE  = 4;  // one fb pixel covers 4x4 screen pixels
    localparam int PAL_SIZE  = 16;

    // widths
    localparam int CORDW    = 16;                 // signed coordinates
    localparam int CIDXW    = 4;                  // colour index
    localparam int CHANW    = 4;                  // bits per colour channel
    localparam int FB_ADDRW = $clog2(FB_PIXELS);  // 15
    localparam int LB_IDXW  = 8;                  // linebuffer entry index
    localparam int SCALEW   = $clog2(FB_SCALE);   // scale line counter

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [CIDXW-1:0]        cidx_t;
    typedef logic [3*CHANW-1:0]      colr_t;     // {r, g, b}
    typedef logic [FB_ADDRW-1:0]     fb_addr_t;
    typedef logic [LB_IDXW-1:0]      lb_idx_t;
    typedef logic [7:0]              chan8_t;

    typedef enum logic {DST_FB, DST_PAL} host_dst_e;
    typedef enum logic [1:0] {WR_IDLE, WR_ACK, WR_WAIT_DROP} wr_state_e;

    // screen position travelling alongside each pixel
    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   de;
        logic   frame;
    } pix_pos_t;

    // one host write, data[CIDXW-1:0] only for framebuffer targets
    typedef struct packed {
        host_dst_e sel;
        fb_addr_t  addr;
        colr_t     data;
    } host_wr_t;

endpackage

/* src/display_timing.sv */
////////////////////////////////////////////////////////////////////////////
// 640x480 screen position counters, one pixel per clk_pix, with de,
// frame and line pulses for the fetch and pixel pipeline
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module display_timing (
    input  logic             clk_pix,
    input  logic             arst_n_i,
    output fb_pkg::pix_pos_t pos_o,    // current position, de and frame
    output logic             line_o    // start of every line
);

    fb_pkg::coord_t sx_q;
    fb_pkg::coord_t sy_q;

    always_ff @(posedge clk_pix or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sx_q <= fb_pkg::coord_t'(-fb_pkg::H_BLANK);
            sy_q <= fb_pkg::coord_t'(-fb_pkg::V_BLANK);
        end else if (sx_q == fb_pkg::coord_t'(fb_pkg::H_RES - 1)) begin
            sx_q <= fb_pkg::coord_t'(-fb_pkg::H_BLANK);  // wrap into h blanking
            if (sy_q == fb_pkg::coord_t'(fb_pkg::V_RES - 1)) begin
                sy_q <= fb_pkg::coord_t'(-fb_pkg::V_BLANK);  // new frame
            end else begin
                sy_q <= sy_q + fb_pkg::coord_t'(1);
            end
        end else begin
            sx_q <= sx_q + fb_pkg::coord_t'(1);
        end
    end

    always_comb begin
        pos_o.sx    = sx_q;
        pos_o.sy    = sy_q;
        pos_o.de    = (sx_q >= 0) && (sy_q >= 0);  // active area only
        pos_o.frame = (sx_q == fb_pkg::coord_t'(-fb_pkg::H_BLANK))
                   && (sy_q == fb_pkg::coord_t'(-fb_pkg::V_BLANK));
        line_o      = (sx_q == fb_pkg::coord_t'(-fb_pkg::H_BLANK));
    end

    // both counters stay inside blanking plus active range
    a_coord_range: assert property (@(posedge clk_pix) disable iff (!arst_n_i)
        sx_q >= fb_pkg::coord_t'(-fb_pkg::H_BLANK) && sx_q < fb_pkg::coord_t'(fb_pkg::H_RES)
        && sy_q >= fb_pkg::coord_t'(-fb_pkg::V_BLANK) && sy_q < fb_pkg::coord_t'(fb_pkg::V_RES))
        else $error("display_timing: coordinate out of range");

endmodule

/* src/host_write_port.sv */
////////////////////////////////////////////////////////////////////////////
// four-phase req/ack host port, one write strobe per request, steered
// to the framebuffer RAM or the palette by the sel field
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module host_write_port (
    input  logic             clk_pix,
    input  logic             arst_n_i,
    input  logic             req_i,       // host request, held until ack
    input  fb_pkg::host_wr_t wr_i,        // stable while req high
    output logic             ack_o,
    output logic             fb_we_o,
    output fb_pkg::fb_addr_t fb_waddr_o,
    output fb_pkg::cidx_t    fb_wdata_o,
    output logic             pal_we_o,
    output fb_pkg::cidx_t    pal_idx_o,
    output fb_pkg::colr_t    pal_colr_o
);

    fb_pkg::wr_state_e state_q;
    fb_pkg::wr_state_e state_d;
    logic              take;  // request accepted this cycle

    always_comb begin
        take    = (state_q == fb_pkg::WR_IDLE) && req_i;
        state_d = state_q;
        unique case (state_q)
            fb_pkg::WR_IDLE:      if (req_i) state_d = fb_pkg::WR_ACK;
            fb_pkg::WR_ACK:       state_d = req_i ? fb_pkg::WR_WAIT_DROP : fb_pkg::WR_IDLE;
            fb_pkg::WR_WAIT_DROP: if (!req_i) state_d = fb_pkg::WR_IDLE;  // req seen low
            default:              state_d = fb_pkg::WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_pix or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= fb_pkg::WR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ack high from the cycle after the write until req has dropped
    assign ack_o = (state_q != fb_pkg::WR_IDLE);

    // write strobes, single cycle per request
    assign fb_we_o    = take && (wr_i.sel == fb_pkg::DST_FB);
    assign pal_we_o   = take && (wr_i.sel == fb_pkg::DST_PAL);
    assign fb_waddr_o = wr_i.addr;
    assign fb_wdata_o = wr_i.data[fb_pkg::CIDXW-1:0];  // index only
    assign pal_idx_o  = wr_i.addr[fb_pkg::CIDXW-1:0];
    assign pal_colr_o = wr_i.data;

    // host keeps the payload still until ack answers
    a_wr_stable: assert property (@(posedge clk_pix) disable iff (!arst_n_i)
        (req_i && !ack_o) |=> (!req_i || $stable(wr_i)))
        else $error("host_write_port: wr_i changed before ack");

    // address fits the selected target
    a_addr_range: assert property (@(posedge clk_pix) disable iff (!arst_n_i)
        take |-> ((wr_i.sel == fb_pkg::DST_FB)
            ? (wr_i.addr < fb_pkg::fb_addr_t'(fb_pkg::FB_PIXELS))
            : (wr_i.addr < fb_pkg::fb_addr_t'(fb_pkg::PAL_SIZE))))
        else $error("host_write_port: address out of range");

endmodule

/* src/fb_bram.sv */
////////////////////////////////////////////////////////////////////////////
// framebuffer RAM, 160x120 colour indices, host write port and
// fetch read port with a one-cycle registered read
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fb_bram (
    input  logic             clk_pix,
    input  logic             we_i,
    input  fb_pkg::fb_addr_t waddr_i,
    input  fb_pkg::cidx_t    wdata_i,
    input  fb_pkg::fb_addr_t raddr_i,
    output fb_pkg::cidx_t    rdata_o   // valid one cycle after raddr_i
);

    fb_pkg::cidx_t mem [fb_pkg::FB_PIXELS];  // contents only from the host

    always_ff @(posedge clk_pix) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read port
    always_ff @(posedge clk_pix) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

/* src/lb_fetch.sv */
////////////////////////////////////////////////////////////////////////////
// copies one framebuffer row into the linebuffer on every FB_SCALE-th
// active line, 160 reads starting at the line pulse
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lb_fetch (
    input  logic             clk_pix,
    input  logic             arst_n_i,
    input  fb_pkg::pix_pos_t pos_i,
    input  logic             line_i,
    output fb_pkg::fb_addr_t raddr_o,    // to fb_bram read port
    output logic             lb_we_o,    // aligned with fb rdata
    output fb_pkg::lb_idx_t  lb_widx_o
);

    logic [fb_pkg::SCALEW-1:0] scale_q;     // line within current fb row
    logic [fb_pkg::SCALEW-1:0] scale_nxt;
    logic                      start;
    logic                      busy_q;      // read addresses in flight
    fb_pkg::lb_idx_t           col_q;
    fb_pkg::fb_addr_t          row_base_q;  // row * FB_WIDTH
    logic                      we_q;
    fb_pkg::lb_idx_t           widx_q;

    always_comb begin
        if (pos_i.sy == 0) begin
            scale_nxt = '0;  // first active line restarts the count
        end else if (scale_q == fb_pkg::SCALEW'(fb_pkg::FB_SCALE - 1)) begin
            scale_nxt = '0;
        end else begin
            scale_nxt = scale_q + 1'b1;
        end
        start = line_i && (pos_i.sy >= 0) && (pos_i.sy < fb_pkg::coord_t'(fb_pkg::V_RES))
             && (scale_nxt == '0);
    end

    always_ff @(posedge clk_pix or negedge arst_n_i) begin
        if (!arst_n_i) begin
            scale_q    <= '0;
            busy_q     <= 1'b0;
            col_q      <= '0;
            row_base_q <= '0;
            we_q       <= 1'b0;
        end else begin
            we_q <= busy_q;  // RAM read latency
            if (line_i) scale_q <= scale_nxt;
            if (start) begin
                busy_q <= 1'b1;
                col_q  <= '0;
            end else if (busy_q) begin
                if (col_q == fb_pkg::lb_idx_t'(fb_pkg::FB_WIDTH - 1)) begin
                    busy_q     <= 1'b0;
                    row_base_q <= row_base_q + fb_pkg::fb_addr_t'(fb_pkg::FB_WIDTH);
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
            if (pos_i.frame) row_base_q <= '0;  // back to row 0
        end
    end

    always_ff @(posedge clk_pix) begin
        widx_q <= col_q;  // payload follows the strobe
    end

    assign raddr_o   = row_base_q + fb_pkg::fb_addr_t'(col_q);
    assign lb_we_o   = we_q;
    assign lb_widx_o = widx_q;

endmodule

/* src/linebuffer.sv */
////////////////////////////////////////////////////////////////////////////
// one fb row of colour indices, read back at sx / FB_SCALE so each entry
// repeats 4 times across the line; position is piped with the index
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module linebuffer (
    input  logic             clk_pix,
    input  logic             we_i,
    input  fb_pkg::lb_idx_t  widx_i,
    input  fb_pkg::cidx_t    wdata_i,
    input  fb_pkg::pix_pos_t pos_i,    // from display_timing
    output fb_pkg::cidx_t    cidx_o,   // one cycle after pos_i
    output fb_pkg::pix_pos_t pos_o     // same cycle as cidx_o
);

    fb_pkg::cidx_t   mem [fb_pkg::FB_WIDTH];
    fb_pkg::lb_idx_t ridx;

    // horizontal scaling via the read index
    always_comb begin
        if (pos_i.de) begin
            ridx = fb_pkg::lb_idx_t'(pos_i.sx / fb_pkg::coord_t'(fb_pkg::FB_SCALE));
        end else begin
            ridx = '0;  // blanking, entry 0 is don't care
        end
    end

    always_ff @(posedge clk_pix) begin
        if (we_i) begin
            mem[widx_i] <= wdata_i;
        end
    end

    // index and position leave together
    always_ff @(posedge clk_pix) begin
        cidx_o <= mem[ridx];
        pos_o  <= pos_i;
    end

    // fetch never writes past the stored row
    a_widx_range: assert property (@(posedge clk_pix)
        we_i |-> (widx_i < fb_pkg::lb_idx_t'(fb_pkg::FB_WIDTH)))
        else $error("linebuffer: write index out of range");

endmodule

/* src/clut_paint.sv */
////////////////////////////////////////////////////////////////////////////
// writable 16-entry palette, paint-area masking and registered 8-bit
// channel output together with the matching screen position
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module clut_paint (
    input  logic             clk_pix,
    input  logic             arst_n_i,
    input  logic             pal_we_i,
    input  fb_pkg::cidx_t    pal_idx_i,
    input  fb_pkg::colr_t    pal_colr_i,
    input  fb_pkg::cidx_t    cidx_i,     // from linebuffer
    input  fb_pkg::pix_pos_t pos_i,      // aligned with cidx_i
    output fb_pkg::coord_t   sx_o,
    output fb_pkg::coord_t   sy_o,
    output logic             de_o,
    output logic             frame_o,
    output fb_pkg::chan8_t   r_o,
    output fb_pkg::chan8_t   g_o,
    output fb_pkg::chan8_t   b_o
);

    fb_pkg::colr_t pal_q [fb_pkg::PAL_SIZE];
    fb_pkg::colr_t colr;   // masked lookup result
    logic          paint;

    always_ff @(posedge clk_pix or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < fb_pkg::PAL_SIZE; i++) pal_q[i] <= '0;  // all black
        end else if (pal_we_i) begin
            pal_q[pal_idx_i] <= pal_colr_i;
        end
    end

    always_comb begin
        paint = pos_i.de
             && (pos_i.sx >= 0) && (pos_i.sx < fb_pkg::coord_t'(fb_pkg::H_RES))
             && (pos_i.sy >= 0) && (pos_i.sy < fb_pkg::coord_t'(fb_pkg::V_RES));
        colr  = paint ? pal_q[cidx_i] : '0;  // black outside paint area
    end

    always_ff @(posedge clk_pix or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_o    <= 1'b0;
            frame_o <= 1'b0;
            r_o     <= '0;
            g_o     <= '0;
            b_o     <= '0;
        end else begin
            de_o    <= pos_i.de;
            frame_o <= pos_i.frame;
            r_o     <= {2{colr[2*fb_pkg::CHANW +: fb_pkg::CHANW]}};  // 4 -> 8 bits
            g_o     <= {2{colr[fb_pkg::CHANW +: fb_pkg::CHANW]}};
            b_o     <= {2{colr[0 +: fb_pkg::CHANW]}};
        end
    end

    // coordinates ride along with the pixel
    always_ff @(posedge clk_pix) begin
        sx_o <= pos_i.sx;
        sy_o <= pos_i.sy;
    end

endmodule

/* src/fb_scale_top.sv */
////////////////////////////////////////////////////////////////////////////
// scaled framebuffer display top, host write port in, 640x480 pixels
// with coordinates out two cycles behind the timing counters
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fb_scale_top (
    input  logic             clk_pix,
    input  logic             arst_n_i,
    input  logic             host_req_i,
    input  fb_pkg::host_wr_t host_wr_i,
    output logic             host_ack_o,
    output fb_pkg::coord_t   sx_o,
    output fb_pkg::coord_t   sy_o,
    output logic             de_o,
    output logic             frame_o,
    output fb_pkg::chan8_t   r_o,
    output fb_pkg::chan8_t   g_o,
    output fb_pkg::chan8_t   b_o
);

    fb_pkg::pix_pos_t pos;       // timing position
    logic             line;
    logic             fb_we;
    fb_pkg::fb_addr_t fb_waddr;
    fb_pkg::cidx_t    fb_wdata;
    logic             pal_we;
    fb_pkg::cidx_t    pal_idx;
    fb_pkg::colr_t    pal_colr;
    fb_pkg::fb_addr_t fb_raddr;
    fb_pkg::cidx_t    fb_rdata;
    logic             lb_we;
    fb_pkg::lb_idx_t  lb_widx;
    fb_pkg::cidx_t    lb_cidx;
    fb_pkg::pix_pos_t lb_pos;    // position one stage later

    display_timing display_timing_i (
        .clk_pix(clk_pix), .arst_n_i(arst_n_i), .pos_o(pos), .line_o(line)
    );

    host_write_port host_write_port_i (
        .clk_pix(clk_pix), .arst_n_i(arst_n_i), .req_i(host_req_i), .wr_i(host_wr_i),
        .ack_o(host_ack_o), .fb_we_o(fb_we), .fb_waddr_o(fb_waddr), .fb_wdata_o(fb_wdata),
        .pal_we_o(pal_we), .pal_idx_o(pal_idx), .pal_colr_o(pal_colr)
    );

    fb_bram fb_bram_i (
        .clk_pix(clk_pix), .we_i(fb_we), .waddr_i(fb_waddr), .wdata_i(fb_wdata),
        .raddr_i(fb_raddr), .rdata_o(fb_rdata)
    );

    lb_fetch lb_fetch_i (
        .clk_pix(clk_pix), .arst_n_i(arst_n_i), .pos_i(pos), .line_i(line),
        .raddr_o(fb_raddr), .lb_we_o(lb_we), .lb_widx_o(lb_widx)
    );

    linebuffer linebuffer_i (
        .clk_pix(clk_pix), .we_i(lb_we), .widx_i(lb_widx), .wdata_i(fb_rdata),
        .pos_i(pos), .cidx_o(lb_cidx), .pos_o(lb_pos)
    );

    clut_paint clut_paint_i (
        .clk_pix(clk_pix), .arst_n_i(arst_n_i), .pal_we_i(pal_we), .pal_idx_i(pal_idx),
        .pal_colr_i(pal_colr), .cidx_i(lb_cidx), .pos_i(lb_pos), .sx_o(sx_o), .sy_o(sy_o),
        .de_o(de_o), .frame_o(frame_o), .r_o(r_o), .g_o(g_o), .b_o(b_o)
    );

endmodule

/* tests/tb_fb_scale.sv */
////////////////////////////////////////////////////////////////////////////
// directed testbench for fb_scale_top, host writes through the req/ack
// port and every output pixel is checked against model arrays
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_fb_scale;

    localparam int FRAME_CYC = 800 * 525;  // 420000 clocks per frame
    localparam int WR_CYC    = 6;
    localparam int N_WR      = 2 * fb_pkg::FB_PIXELS + 2 * fb_pkg::PAL_SIZE + 4;
    localparam int LIMIT     = 4 * (N_WR * WR_CYC + 3 * FRAME_CYC);
    localparam int ACK_WAIT  = 8;  // clocks allowed for one ack edge

    logic             clk_pix;
    logic             arst_n_i;
    logic             host_req_i;
    fb_pkg::host_wr_t host_wr_i;
    logic             host_ack_o;
    fb_pkg::coord_t   sx_o;
    fb_pkg::coord_t   sy_o;
    logic             de_o;
    logic             frame_o;
    fb_pkg::chan8_t   r_o;
    fb_pkg::chan8_t   g_o;
    fb_pkg::chan8_t   b_o;

    fb_pkg::cidx_t fb_model [fb_pkg::FB_PIXELS];  // mirrors the fb RAM
    fb_pkg::colr_t pal_model [fb_pkg::PAL_SIZE];
    int            cyc_cnt;

    fb_scale_top fb_scale_top_i (
        .clk_pix(clk_pix), .arst_n_i(arst_n_i), .host_req_i(host_req_i),
        .host_wr_i(host_wr_i), .host_ack_o(host_ack_o), .sx_o(sx_o), .sy_o(sy_o),
        .de_o(de_o), .frame_o(frame_o), .r_o(r_o), .g_o(g_o), .b_o(b_o)
    );

    initial begin
        clk_pix = 1'b0;
        forever #4 clk_pix = ~clk_pix;  // 8 ns period
    end

    // run limit
    always @(posedge clk_pix) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= LIMIT) begin
            $display("timeout: cycle limit reached before the tests finished");
            $display("Simulation FAILED");
            $fatal(1, "run aborted on timeout");
        end
    end

    task automatic check_eq(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "handshake failure");
    endtask

    // waits on falling edges for ack to reach a level
    task automatic wait_ack(input logic level, input string what);
        int n;
        n = 0;
        while (host_ack_o !== level) begin
            @(negedge clk_pix);
            n++;
            if (n > ACK_WAIT) stop_on(what);
        end
    endtask

    task automatic host_write(input fb_pkg::host_dst_e sel, input int addr, input int data);
        @(negedge clk_pix);
        check_eq("host_ack_o", int'(host_ack_o), 0);  // idle before req
        host_wr_i.sel  = sel;
        host_wr_i.addr = fb_pkg::fb_addr_t'(addr);
        host_wr_i.data = fb_pkg::colr_t'(data);
        host_req_i     = 1'b1;
        wait_ack(1'b1, "host ack never rose after req");
        host_req_i = 1'b0;
        wait_ack(1'b0, "host ack never fell after req dropped");
        if (sel == fb_pkg::DST_FB) fb_model[addr] = fb_pkg::cidx_t'(data);
        else pal_model[addr % fb_pkg::PAL_SIZE] = fb_pkg::colr_t'(data);
    endtask

    // one output cycle against the model, sampled mid-cycle
    task automatic check_pixel();
        int            sx;
        int            sy;
        fb_pkg::colr_t c;
        sx = int'(sx_o);
        sy = int'(sy_o);
        check_eq("de_o", int'(de_o), int'(sx >= 0 && sy >= 0));
        if (frame_o) begin
            check_eq("sx_o at frame", sx, -fb_pkg::H_BLANK);
            check_eq("sy_o at frame", sy, -fb_pkg::V_BLANK);
        end
        c = '0;  // black in blanking
        if (de_o) begin
            c = pal_model[fb_model[(sy / fb_pkg::FB_SCALE) * fb_pkg::FB_WIDTH
                + sx / fb_pkg::FB_SCALE]];
        end
        check_eq("r_o", int'(r_o), int'({c[11:8], c[11:8]}));  // channel doubled
        check_eq("g_o", int'(g_o), int'({c[7:4], c[7:4]}));
        check_eq("b_o", int'(b_o), int'({c[3:0], c[3:0]}));
    endtask

    task automatic wait_frame();
        do @(negedge clk_pix); while (!frame_o);
    endtask

    // checks every cycle up to and including the next frame pulse
    task automatic scan_frame(input int blk_row, input int blk_col,
                              output int cycles, output int de_cnt, output int blk_cnt);
        cycles  = 0;
        de_cnt  = 0;
        blk_cnt = 0;
        do begin
            @(negedge clk_pix);
            cycles++;
            check_pixel();
            if (de_o) begin
                de_cnt++;
                if (int'(sy_o) / fb_pkg::FB_SCALE == blk_row
                    && int'(sx_o) / fb_pkg::FB_SCALE == blk_col) blk_cnt++;
            end
        end while (!frame_o);
    endtask

    task automatic test_reset();
        check_eq("de_o", int'(de_o), 0);
        check_eq("frame_o", int'(frame_o), 0);
        check_eq("host_ack_o", int'(host_ack_o), 0);
        while (!de_o) @(negedge clk_pix);  // first active pixel
        check_eq("sx_o", int'(sx_o), 0);
        check_eq("sy_o", int'(sy_o), 0);
    endtask

    // palette entry 5 written here shows up in the following scaled frame
    task automatic test_handshake();
        @(negedge clk_pix);
        check_eq("host_ack_o", int'(host_ack_o), 0);
        host_wr_i.sel  = fb_pkg::DST_PAL;
        host_wr_i.addr = fb_pkg::fb_addr_t'(5);
        host_wr_i.data = fb_pkg::colr_t'($urandom);
        host_req_i     = 1'b1;
        wait_ack(1'b1, "host ack never rose after req");
        pal_model[5] = host_wr_i.data;
        repeat (3) begin
            @(negedge clk_pix);
            check_eq("host_ack_o", int'(host_ack_o), 1);  // held while req high
        end
        host_req_i = 1'b0;
        wait_ack(1'b0, "host ack never fell after req dropped");
        @(negedge clk_pix);
        check_eq("host_ack_o", int'(host_ack_o), 0);
    endtask

    task automatic test_palette_fill();
        int k;
        int cycles;
        int de_cnt;
        int blk_cnt;
        for (int i = 0; i < fb_pkg::PAL_SIZE; i++) host_write(fb_pkg::DST_PAL, i, int'($urandom));
        k = int'($urandom % fb_pkg::PAL_SIZE);
        for (int a = 0; a < fb_pkg::FB_PIXELS; a++) host_write(fb_pkg::DST_FB, a, k);
        wait_frame();
        scan_frame(-1, -1, cycles, de_cnt, blk_cnt);
        check_eq("frame period", cycles, FRAME_CYC);
        check_eq("active pixels", de_cnt, fb_pkg::H_RES * fb_pkg::V_RES);
    endtask

    task automatic test_scaling();
        int cycles;
        int de_cnt;
        int blk_cnt;
        for (int a = 0; a < fb_pkg::FB_PIXELS; a++) begin
            host_write(fb_pkg::DST_FB, a, int'($urandom % fb_pkg::PAL_SIZE));
        end
        wait_frame();
        scan_frame(-1, -1, cycles, de_cnt, blk_cnt);
        check_eq("frame period", cycles, FRAME_CYC);
        check_eq("active pixels", de_cnt, fb_pkg::H_RES * fb_pkg::V_RES);
    endtask

    // starts on a frame pulse, so both writes land in vertical blanking
    task automatic test_live_update();
        int addr;
        int nidx;
        int cycles;
        int de_cnt;
        int blk_cnt;
        addr = int'($urandom % fb_pkg::FB_PIXELS);
        nidx = int'(fb_model[addr]) ^ int'(1 + $urandom % 15);  // always a new index
        host_write(fb_pkg::DST_FB, addr, nidx);
        host_write(fb_pkg::DST_PAL, nidx, int'(pal_model[nidx]) ^ int'(1 + $urandom % 4095));
        check_eq("sy_o blanking", int'(sy_o < 0), 1);
        scan_frame(addr / fb_pkg::FB_WIDTH, addr % fb_pkg::FB_WIDTH, cycles, de_cnt, blk_cnt);
        check_eq("block pixels", blk_cnt, fb_pkg::FB_SCALE * fb_pkg::FB_SCALE);
    endtask

    initial begin
        arst_n_i   = 1'b0;
        host_req_i = 1'b0;
        host_wr_i  = '0;
        cyc_cnt    = 0;
        void'($urandom(32'hecd758c3));
        for (int a = 0; a < fb_pkg::FB_PIXELS; a++) fb_model[a] = '0;
        for (int i = 0; i < fb_pkg::PAL_SIZE; i++) pal_model[i] = '0;  // palette resets black
        repeat (3) @(negedge clk_pix);
        check_eq("de_o in reset", int'(de_o), 0);
        arst_n_i = 1'b1;
        test_reset();
        test_palette_fill();
        test_handshake();
        test_scaling();
        test_live_update();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* project.f */
src/fb_pkg.sv
src/display_timing.sv
src/host_write_port.sv
src/fb_bram.sv
src/lb_fetch.sv
src/linebuffer.sv
src/clut_paint.sv
src/fb_scale_top.sv
tests/tb_fb_scale.sv

/* run.sh */
#!/bin/sh
# build and run the fb_scale testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fb_scale -f project.f -Mdir obj_dir -o sim_fb_scale
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_fb_scale)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
